/* ncpu_commit.f */
logic/cmt_pkg.sv
logic/cmt_select.sv
logic/cmt_branch_resolve.sv
logic/cmt_lsu_ctrl.sv
logic/cmt_top.sv
tb/cmt_assertions.sv
tb/cmt_tb.sv

/* Bender.yml */
package:
  name: ncpu_commit

sources:
  # RTL, package first
  - files:
      - logic/cmt_pkg.sv
      - logic/cmt_select.sv
      - logic/cmt_branch_resolve.sv
      - logic/cmt_lsu_ctrl.sv
      - logic/cmt_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tb/cmt_assertions.sv
      - tb/cmt_tb.sv

/* tb/cmt_tb.sv */
/*
 Random ROB stream against the commit stage with a 16-word memory model.
 Load/store addresses fall in 0x1000..0x103F and are naturally aligned.
 Stops at the first mismatch; ends after 2000 commits.
 */

module cmt_tb;
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct {
      cmt_pkg::lsu_opc_e           opc;
      cmt_pkg::br_kind_e           br;
      logic                        fls;
      logic [cmt_pkg::PC_W-1:0]    fls_tgt;
      logic [cmt_pkg::PC_W-1:0]    pc;
      logic                        bpu_taken;
      logic [cmt_pkg::PC_W-1:0]    bpu_tgt;
      logic [cmt_pkg::DW-1:0]      opera;
      logic [cmt_pkg::DW-1:0]      operb;
      logic [cmt_pkg::PRF_AW-1:0]  prd;
      logic                        prd_we;
   } rob_entry_t;

   logic clk;
   logic rst;
   logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_valid;
   cmt_pkg::lsu_opc_e [cmt_pkg::COMMIT_WIDTH-1:0] cmt_lsu_opc;
   cmt_pkg::br_kind_e [cmt_pkg::COMMIT_WIDTH-1:0] cmt_br_kind;
   logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_fls;
   logic [cmt_pkg::PC_W-1:0]   cmt_fls_tgt;
   logic [cmt_pkg::PC_W-1:0]   cmt_pc0;
   logic                       cmt_bpu_taken;
   logic [cmt_pkg::PC_W-1:0]   cmt_bpu_tgt;
   logic [cmt_pkg::DW-1:0]     cmt_opera0;
   logic [cmt_pkg::DW-1:0]     cmt_operb0;
   logic [cmt_pkg::PRF_AW-1:0] cmt_prd0;
   logic                       cmt_prd_we0;
   logic [cmt_pkg::COMMIT_WIDTH-1:0] cmt_fire;
   logic [cmt_pkg::POP_W-1:0]  cmt_pop_size;
   logic                       flush;
   logic [cmt_pkg::PC_W-1:0]   flush_tgt;
   logic                       bpu_wb;
   cmt_pkg::br_kind_e          bpu_wb_kind;
   logic                       bpu_wb_taken;
   logic [cmt_pkg::PC_W-1:0]   bpu_wb_pc;
   logic [cmt_pkg::PC_W-1:0]   bpu_wb_npc_act;
   logic                       prf_we;
   logic [cmt_pkg::PRF_AW-1:0] prf_waddr;
   logic [cmt_pkg::DW-1:0]     prf_wdata;
   logic                       dbus_req_valid;
   logic                       dbus_req_ready;
   logic                       dbus_req_write;
   logic [cmt_pkg::AW-1:0]     dbus_req_addr;
   logic [cmt_pkg::DW-1:0]     dbus_req_wdata;
   logic [cmt_pkg::STRB_W-1:0] dbus_req_strb;
   logic                       dbus_rsp_valid;
   logic [cmt_pkg::DW-1:0]     dbus_rsp_rdata;

   rob_entry_t                 rob_q[$];
   logic [cmt_pkg::DW-1:0]     mem [16];
   logic                       flush_exp = 1'b0;     // Predicted flush for this cycle
   logic [cmt_pkg::PC_W-1:0]   flush_tgt_exp = '0;
   int                         exp_pop = 0;
   int                         phase = 0;            // 0 idle, 1 request, 2 response
   logic                       rsp_pending = 1'b0;
   int                         rsp_delay = 0;
   logic [cmt_pkg::DW-1:0]     rsp_word = '0;
   int                         commits = 0;
   int                         idle_cycles = 0;
   int                         n_load = 0;
   int                         n_store = 0;
   int                         n_br = 0;
   int                         n_fls = 0;
   int                         n_multi = 0;
   int                         n_stall = 0;

   cmt_top u_cmt_top (.*);

   always #50 clk = ~clk;

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped");
   endtask

   function automatic rob_entry_t new_entry();
      rob_entry_t e;
      int         r;
      int         low;
      r           = $urandom_range(0, 99);
      e.opc       = cmt_pkg::LSU_NONE;
      e.br        = cmt_pkg::BR_NONE;
      e.fls       = 1'b0;
      e.fls_tgt   = $urandom();
      e.pc        = $urandom();
      e.bpu_taken = $urandom_range(0, 1);
      e.bpu_tgt   = $urandom();
      e.operb     = $urandom();
      e.prd       = $urandom();
      e.prd_we    = ($urandom_range(0, 3) != 0);
      low         = $urandom_range(0, 3);
      if (r < 16)
      begin
         e.opc = cmt_pkg::lsu_opc_e'($urandom_range(1, 8));
         if (e.opc inside {cmt_pkg::LSU_LH, cmt_pkg::LSU_LHU, cmt_pkg::LSU_SH})
            low = low & 2;                                 // Halfword aligned
         else if (e.opc inside {cmt_pkg::LSU_LW, cmt_pkg::LSU_SW})
            low = 0;
      end
      else if (r < 30)
      begin
         e.br  = cmt_pkg::br_kind_e'($urandom_range(1, 3));
         e.fls = $urandom_range(0, 1);                     // Mispredicted
      end
      else if (r < 36)
         e.fls = 1'b1;
      e.opera = 32'h1000 | ($urandom_range(0, 15) << 2) | low;
      return e;
   endfunction

   function automatic logic [cmt_pkg::COMMIT_WIDTH-1:0] ref_fire(
      input logic [cmt_pkg::COMMIT_WIDTH-1:0]              valid,
      input cmt_pkg::lsu_opc_e [cmt_pkg::COMMIT_WIDTH-1:0] opc,
      input cmt_pkg::br_kind_e [cmt_pkg::COMMIT_WIDTH-1:0] br,
      input logic [cmt_pkg::COMMIT_WIDTH-1:0]              fls,
      input logic                                          flush_now,
      input logic                                          rsp_now);
      logic [cmt_pkg::COMMIT_WIDTH-1:0] ser;
      logic [cmt_pkg::COMMIT_WIDTH-1:0] elig;
      logic                             enable;
      for (int i = 0; i < cmt_pkg::COMMIT_WIDTH; i++)
         ser[i] = (opc[i] != cmt_pkg::LSU_NONE) || (br[i] != cmt_pkg::BR_NONE) || fls[i];
      elig[0] = 1'b1;
      elig[1] = !ser[0] && !ser[1];
      for (int j = 2; j < cmt_pkg::COMMIT_WIDTH; j++)
         elig[j] = elig[j-1] && !ser[j];
      enable = !(valid[0] && opc[0] != cmt_pkg::LSU_NONE) || rsp_now;
      if (!enable || flush_now)
         return '0;
      return valid & elig;
   endfunction

   function automatic int count_ones(input logic [cmt_pkg::COMMIT_WIDTH-1:0] v);
      int n;
      n = 0;
      for (int i = 0; i < cmt_pkg::COMMIT_WIDTH; i++)
         n += v[i];
      return n;
   endfunction

   function automatic logic [cmt_pkg::DW-1:0] load_value(input cmt_pkg::lsu_opc_e opc,
      input logic [cmt_pkg::DW-1:0] word, input logic [1:0] low);
      logic [cmt_pkg::DW-1:0] sh;
      sh = word >> (8 * low);
      case (opc)
         cmt_pkg::LSU_LB:  return {{24{sh[7]}}, sh[7:0]};
         cmt_pkg::LSU_LBU: return {24'h0, sh[7:0]};
         cmt_pkg::LSU_LH:  return {{16{sh[15]}}, sh[15:0]};
         cmt_pkg::LSU_LHU: return {16'h0, sh[15:0]};
         default:          return word;
      endcase
   endfunction

   task automatic check_fire(input logic [cmt_pkg::COMMIT_WIDTH-1:0] exp_fire, got_fire,
      input logic [cmt_pkg::POP_W-1:0] exp_pop_size, got_pop_size);
      if (got_fire !== exp_fire)
         fail_now($sformatf("ERROR cmt_fire exp=%h got=%h", exp_fire, got_fire));
      if (got_pop_size !== exp_pop_size)
         fail_now($sformatf("ERROR cmt_pop_size exp=%h got=%h", exp_pop_size, got_pop_size));
   endtask

   task automatic check_flush(input logic exp_fl, got_fl,
      input logic [cmt_pkg::PC_W-1:0] exp_tgt, got_tgt);
      if (got_fl !== exp_fl)
         fail_now($sformatf("ERROR flush exp=%h got=%h", exp_fl, got_fl));
      if (exp_fl && got_tgt !== exp_tgt)
         fail_now($sformatf("ERROR flush_tgt exp=%h got=%h", exp_tgt, got_tgt));
   endtask

   task automatic check_bpu(input logic exp_wb, got_wb,
      input cmt_pkg::br_kind_e exp_kind, got_kind, input logic exp_taken, got_taken,
      input logic [cmt_pkg::PC_W-1:0] exp_pc, got_pc, exp_npc, got_npc);
      if (got_wb !== exp_wb)
         fail_now($sformatf("ERROR bpu_wb exp=%h got=%h", exp_wb, got_wb));
      if (!exp_wb)
         return;
      if (got_kind !== exp_kind)
         fail_now($sformatf("ERROR bpu_wb_kind exp=%h got=%h", exp_kind, got_kind));
      if (got_taken !== exp_taken)
         fail_now($sformatf("ERROR bpu_wb_taken exp=%h got=%h", exp_taken, got_taken));
      if (got_pc !== exp_pc)
         fail_now($sformatf("ERROR bpu_wb_pc exp=%h got=%h", exp_pc, got_pc));
      if (got_npc !== exp_npc)
         fail_now($sformatf("ERROR bpu_wb_npc_act exp=%h got=%h", exp_npc, got_npc));
   endtask

   task automatic check_bus_req(input logic exp_valid, input rob_entry_t h);
      logic                       st;
      logic [cmt_pkg::STRB_W-1:0] strb;
      logic [cmt_pkg::DW-1:0]     wd;
      if (dbus_req_valid !== exp_valid)
         fail_now($sformatf("ERROR dbus_req_valid exp=%h got=%h", exp_valid, dbus_req_valid));
      if (!exp_valid)
         return;
      st   = h.opc inside {cmt_pkg::LSU_SB, cmt_pkg::LSU_SH, cmt_pkg::LSU_SW};
      strb = 4'hf;
      wd   = h.operb;
      if (h.opc == cmt_pkg::LSU_SB)
      begin
         strb = 4'b0001 << h.opera[1:0];
         wd   = {4{h.operb[7:0]}};
      end
      else if (h.opc == cmt_pkg::LSU_SH)
      begin
         strb = h.opera[1] ? 4'b1100 : 4'b0011;
         wd   = {2{h.operb[15:0]}};
      end
      if (dbus_req_write !== st)
         fail_now($sformatf("ERROR dbus_req_write exp=%h got=%h", st, dbus_req_write));
      if (dbus_req_addr !== {h.opera[31:2], 2'b00})
         fail_now($sformatf("ERROR dbus_req_addr exp=%h got=%h",
            {h.opera[31:2], 2'b00}, dbus_req_addr));
      if (st && dbus_req_strb !== strb)
         fail_now($sformatf("ERROR dbus_req_strb exp=%h got=%h", strb, dbus_req_strb));
      if (st && dbus_req_wdata !== wd)
         fail_now($sformatf("ERROR dbus_req_wdata exp=%h got=%h", wd, dbus_req_wdata));
   endtask

   task automatic check_prf(input logic exp_we, got_we,
      input logic [cmt_pkg::PRF_AW-1:0] exp_addr, got_addr,
      input logic [cmt_pkg::DW-1:0] exp_data, got_data);
      if (got_we !== exp_we)
         fail_now($sformatf("ERROR prf_we exp=%h got=%h", exp_we, got_we));
      if (exp_we && got_addr !== exp_addr)
         fail_now($sformatf("ERROR prf_waddr exp=%h got=%h", exp_addr, got_addr));
      if (exp_we && got_data !== exp_data)
         fail_now($sformatf("ERROR prf_wdata exp=%h got=%h", exp_data, got_data));
   endtask

   task automatic check_cycle();
      logic [cmt_pkg::COMMIT_WIDTH-1:0] f;
      rob_entry_t                       h;
      logic                             is_ld;
      logic                             is_st;
      int                               idx;
      int                               pop;
      h     = rob_q[0];
      is_st = h.opc inside {cmt_pkg::LSU_SB, cmt_pkg::LSU_SH, cmt_pkg::LSU_SW};
      is_ld = (h.opc != cmt_pkg::LSU_NONE) && !is_st;
      f     = ref_fire(cmt_valid, cmt_lsu_opc, cmt_br_kind, cmt_fls, flush_exp, dbus_rsp_valid);
      pop   = count_ones(f);
      check_fire(f, cmt_fire, pop, cmt_pop_size);
      check_flush(flush_exp, flush, flush_tgt_exp, flush_tgt);
      check_bpu(f[0] && h.br != cmt_pkg::BR_NONE, bpu_wb, h.br, bpu_wb_kind,
         h.bpu_taken ^ h.fls, bpu_wb_taken, h.pc, bpu_wb_pc,
         h.fls ? h.fls_tgt : h.bpu_tgt, bpu_wb_npc_act);
      check_bus_req(phase == 1, h);
      check_prf(f[0] && is_ld && h.prd_we, prf_we, h.prd, prf_waddr,
         load_value(h.opc, dbus_rsp_rdata, h.opera[1:0]), prf_wdata);

      // Bus phase and memory side of the handshake
      if (phase == 0 && cmt_valid[0] && h.opc != cmt_pkg::LSU_NONE && !flush_exp)
         phase = 1;
      else if (phase == 1 && dbus_req_ready)
      begin
         idx = dbus_req_addr[5:2];
         for (int b = 0; b < cmt_pkg::STRB_W; b++)
            if (dbus_req_write && dbus_req_strb[b])
               mem[idx][8*b +: 8] = dbus_req_wdata[8*b +: 8];
         rsp_word    = mem[idx];
         rsp_pending = 1'b1;
         rsp_delay   = $urandom_range(0, 4);
         phase       = 2;
      end
      else if (phase == 2 && dbus_rsp_valid)
         phase = 0;

      if (f[0] && h.fls)
         flush_tgt_exp = h.fls_tgt;
      flush_exp = f[0] && h.fls && !flush_exp;

      n_load  += (f[0] && is_ld);
      n_store += (f[0] && is_st);
      n_br    += (f[0] && h.br != cmt_pkg::BR_NONE);
      n_fls   += (f[0] && h.fls);
      n_multi += (pop > 1);
      n_stall += (dbus_req_valid && !dbus_req_ready);
      commits += pop;
      exp_pop  = pop;
      idle_cycles = (pop != 0) ? 0 : idle_cycles + 1;
      if (idle_cycles > 200)
         fail_now("no entry committed for 200 cycles, the commit stage is stuck");
   endtask

   task automatic drive_window();
      rob_entry_t e;
      for (int i = 0; i < cmt_pkg::COMMIT_WIDTH; i++)
      begin
         e = rob_q[i];
         // A pending head access keeps its entry valid
         cmt_valid[i]   = ($urandom_range(0, 9) != 0) || (i == 0 && e.opc != cmt_pkg::LSU_NONE);
         cmt_lsu_opc[i] = e.opc;
         cmt_br_kind[i] = e.br;
         cmt_fls[i]     = e.fls;
      end
      e             = rob_q[0];
      cmt_fls_tgt   = e.fls_tgt;
      cmt_pc0       = e.pc;
      cmt_bpu_taken = e.bpu_taken;
      cmt_bpu_tgt   = e.bpu_tgt;
      cmt_opera0    = e.opera;
      cmt_operb0    = e.operb;
      cmt_prd0      = e.prd;
      cmt_prd_we0   = e.prd_we;
   endtask

   task automatic drive_memory();
      dbus_req_ready = ($urandom_range(0, 2) != 0);
      dbus_rsp_valid = 1'b0;
      dbus_rsp_rdata = $urandom();
      if (rsp_pending && rsp_delay == 0)
      begin
         dbus_rsp_valid = 1'b1;
         dbus_rsp_rdata = rsp_word;
         rsp_pending    = 1'b0;
      end
      else if (rsp_pending)
         rsp_delay--;
   endtask

   always @(posedge clk)
   begin
      if (!rst)
         check_cycle();
   end

   always @(negedge clk)
   begin
      for (int i = 0; i < exp_pop; i++)
         void'(rob_q.pop_front());
      if (flush_exp)
         rob_q.delete();                                 // Younger entries are squashed
      while (rob_q.size() < 8)
         rob_q.push_back(new_entry());
      drive_window();
      drive_memory();
   end

   initial
   begin
      int waited;
      void'($urandom(82));
      clk = 1'b0;
      rst = 1'b1;
      cmt_valid = '0;
      for (int i = 0; i < cmt_pkg::COMMIT_WIDTH; i++)
      begin
         cmt_lsu_opc[i] = cmt_pkg::LSU_NONE;
         cmt_br_kind[i] = cmt_pkg::BR_NONE;
      end
      cmt_fls = '0;
      cmt_fls_tgt = '0;
      cmt_pc0 = '0;
      cmt_bpu_taken = 1'b0;
      cmt_bpu_tgt = '0;
      cmt_opera0 = '0;
      cmt_operb0 = '0;
      cmt_prd0 = '0;
      cmt_prd_we0 = 1'b0;
      dbus_req_ready = 1'b0;
      dbus_rsp_valid = 1'b0;
      dbus_rsp_rdata = '0;
      for (int i = 0; i < 16; i++)
         mem[i] = (32'h1000 + 4 * i) * 32'h9e37_79b1;     // Distinct per word address
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      waited = 0;
      while (commits < 2000 && waited < 40000)
      begin
         @(negedge clk);
         waited++;
      end
      if (commits < 2000)
         fail_now("timeout before 2000 entries were committed");
      else if (n_load == 0 || n_store == 0 || n_br == 0 || n_fls == 0 || n_multi == 0
               || n_stall == 0)
         fail_now("some commit behaviors were never exercised");
      else
      begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

/* tb/cmt_assertions.sv */
/*
 Concurrent checks bound into the LSU controller and the branch unit.
 Each bind ties off the port group that its target does not have.
 */

module cmt_assertions
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          req_valid,
   input  logic                          req_ready,
   input  logic                          req_write,
   input  logic [cmt_pkg::AW-1:0]        req_addr,
   input  logic [cmt_pkg::STRB_W-1:0]    req_strb,
   input  logic [cmt_pkg::DW-1:0]        req_wdata,
   input  logic                          flush,
   input  logic                          fls_commit,
   input  logic                          br_commit
);
   timeunit 1ns;
   timeprecision 1ps;

   // Request held until accepted
   a_req_stable : assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid && $stable(req_write) && $stable(req_addr)
         && $stable(req_strb) && $stable(req_wdata))
      else $error("data bus request dropped or changed under back-pressure");

   a_flush_pulse : assert property (@(posedge clk) disable iff (rst)
      flush |=> !flush)
      else $error("flush high for two cycles in a row");

   // Head commits stand for channel 0 firing
   a_no_fire_in_flush : assert property (@(posedge clk) disable iff (rst)
      flush |-> !(fls_commit || br_commit))
      else $error("head entry committed during a flush cycle");

endmodule

bind cmt_lsu_ctrl cmt_assertions u_lsu_assertions
(
   .clk(clk), .rst(rst), .req_valid(dbus_req_valid), .req_ready(dbus_req_ready),
   .req_write(dbus_req_write), .req_addr(dbus_req_addr), .req_strb(dbus_req_strb),
   .req_wdata(dbus_req_wdata), .flush(1'b0), .fls_commit(1'b0), .br_commit(1'b0)
);

bind cmt_branch_resolve cmt_assertions u_br_assertions
(
   .clk(clk), .rst(rst), .req_valid(1'b0), .req_ready(1'b0), .req_write(1'b0),
   .req_addr('0), .req_strb('0), .req_wdata('0), .flush(flush),
   .fls_commit(head_fls_commit), .br_commit(head_br_commit)
);

/* logic/cmt_top.sv */
/*
 Commit stage top level with a four-entry commit window.
 Only channel 0 carries PC, operands, destination and predictor data,
 since every consumer of those is a head-only serializing instruction.
 cmt_fire and cmt_pop_size are combinational from the same cycle.
 */

module cmt_top
(
   input  logic                                          clk,
   input  logic                                          rst,
   // ROB window
   input  logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_valid,
   input  cmt_pkg::lsu_opc_e [cmt_pkg::COMMIT_WIDTH-1:0] cmt_lsu_opc,
   input  cmt_pkg::br_kind_e [cmt_pkg::COMMIT_WIDTH-1:0] cmt_br_kind,
   input  logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_fls,
   input  logic [cmt_pkg::PC_W-1:0]                      cmt_fls_tgt,
   input  logic [cmt_pkg::PC_W-1:0]                      cmt_pc0,
   input  logic                                          cmt_bpu_taken,
   input  logic [cmt_pkg::PC_W-1:0]                      cmt_bpu_tgt,
   input  logic [cmt_pkg::DW-1:0]                        cmt_opera0,
   input  logic [cmt_pkg::DW-1:0]                        cmt_operb0,
   input  logic [cmt_pkg::PRF_AW-1:0]                    cmt_prd0,
   input  logic                                          cmt_prd_we0,
   output logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_fire,
   output logic [cmt_pkg::POP_W-1:0]                     cmt_pop_size,
   // Pipeline flush
   output logic                                          flush,
   output logic [cmt_pkg::PC_W-1:0]                      flush_tgt,
   // Predictor update
   output logic                                          bpu_wb,
   output cmt_pkg::br_kind_e                             bpu_wb_kind,
   output logic                                          bpu_wb_taken,
   output logic [cmt_pkg::PC_W-1:0]                      bpu_wb_pc,
   output logic [cmt_pkg::PC_W-1:0]                      bpu_wb_npc_act,
   // Register file write
   output logic                                          prf_we,
   output logic [cmt_pkg::PRF_AW-1:0]                    prf_waddr,
   output logic [cmt_pkg::DW-1:0]                        prf_wdata,
   // Data bus
   output logic                                          dbus_req_valid,
   input  logic                                          dbus_req_ready,
   output logic                                          dbus_req_write,
   output logic [cmt_pkg::AW-1:0]                        dbus_req_addr,
   output logic [cmt_pkg::DW-1:0]                        dbus_req_wdata,
   output logic [cmt_pkg::STRB_W-1:0]                    dbus_req_strb,
   input  logic                                          dbus_rsp_valid,
   input  logic [cmt_pkg::DW-1:0]                        dbus_rsp_rdata
);

   logic head_lsu_req;
   logic head_br_commit;
   logic head_fls_commit;
   logic lsu_finish;

   cmt_select u_select
   (
      .cmt_valid        (cmt_valid),
      .cmt_lsu_opc      (cmt_lsu_opc),
      .cmt_br_kind      (cmt_br_kind),
      .cmt_fls          (cmt_fls),
      .flush            (flush),
      .lsu_finish       (lsu_finish),
      .cmt_fire         (cmt_fire),
      .cmt_pop_size     (cmt_pop_size),
      .head_lsu_req     (head_lsu_req),
      .head_br_commit   (head_br_commit),
      .head_fls_commit  (head_fls_commit)
   );

   cmt_branch_resolve u_branch_resolve
   (
      .clk              (clk),
      .rst              (rst),
      .head_br_commit   (head_br_commit),
      .head_fls_commit  (head_fls_commit),
      .cmt_fls_tgt      (cmt_fls_tgt),
      .cmt_pc0          (cmt_pc0),
      .cmt_br_kind0     (cmt_br_kind[0]),
      .cmt_bpu_taken    (cmt_bpu_taken),
      .cmt_bpu_tgt      (cmt_bpu_tgt),
      .flush            (flush),
      .flush_tgt        (flush_tgt),
      .bpu_wb           (bpu_wb),
      .bpu_wb_kind      (bpu_wb_kind),
      .bpu_wb_taken     (bpu_wb_taken),
      .bpu_wb_pc        (bpu_wb_pc),
      .bpu_wb_npc_act   (bpu_wb_npc_act)
   );

   cmt_lsu_ctrl u_lsu_ctrl
   (
      .clk              (clk),
      .rst              (rst),
      .head_lsu_req     (head_lsu_req),
      .cmt_lsu_opc0     (cmt_lsu_opc[0]),
      .cmt_opera0       (cmt_opera0),
      .cmt_operb0       (cmt_operb0),
      .cmt_prd_we0      (cmt_prd_we0),
      .dbus_req_ready   (dbus_req_ready),
      .dbus_rsp_valid   (dbus_rsp_valid),
      .dbus_rsp_rdata   (dbus_rsp_rdata),
      .lsu_finish       (lsu_finish),
      .prf_we           (prf_we),
      .prf_wdata        (prf_wdata),
      .dbus_req_valid   (dbus_req_valid),
      .dbus_req_write   (dbus_req_write),
      .dbus_req_addr    (dbus_req_addr),
      .dbus_req_strb    (dbus_req_strb),
      .dbus_req_wdata   (dbus_req_wdata)
   );

   assign prf_waddr = cmt_prd0;                   // Head stays put until finish

endmodule

/* logic/cmt_lsu_ctrl.sv */
/*
 Uncached single-beat load/store sequencer for the ROB head.
 Addresses must be naturally aligned, nothing checks them here.
 One access in flight; the response is taken in any LSU_RESP cycle.
 The strobe marks the addressed bytes for reads as well as writes.
 */

module cmt_lsu_ctrl
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           head_lsu_req,
   input  cmt_pkg::lsu_opc_e              cmt_lsu_opc0,
   input  logic [cmt_pkg::DW-1:0]         cmt_opera0,
   input  logic [cmt_pkg::DW-1:0]         cmt_operb0,
   input  logic                           cmt_prd_we0,
   input  logic                           dbus_req_ready,
   input  logic                           dbus_rsp_valid,
   input  logic [cmt_pkg::DW-1:0]         dbus_rsp_rdata,
   output logic                           lsu_finish,
   output logic                           prf_we,
   output logic [cmt_pkg::DW-1:0]         prf_wdata,
   output logic                           dbus_req_valid,
   output logic                           dbus_req_write,
   output logic [cmt_pkg::AW-1:0]         dbus_req_addr,
   output logic [cmt_pkg::STRB_W-1:0]     dbus_req_strb,
   output logic [cmt_pkg::DW-1:0]         dbus_req_wdata
);

   cmt_pkg::lsu_state_e           state_q;
   cmt_pkg::lsu_state_e           state_d;
   cmt_pkg::lsu_opc_e             opc_q;
   logic [cmt_pkg::AW-1:0]        addr_q;
   logic [cmt_pkg::DW-1:0]        wdata_q;
   logic                          is_store;
   logic                          is_byte;
   logic                          is_half;
   logic                          is_signed;
   logic [7:0]                    ld_byte;
   logic [15:0]                   ld_half;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         cmt_pkg::LSU_IDLE:
            if (head_lsu_req)
               state_d = cmt_pkg::LSU_REQ;
         cmt_pkg::LSU_REQ:
            if (dbus_req_ready)
               state_d = cmt_pkg::LSU_RESP;
         cmt_pkg::LSU_RESP:
            if (dbus_rsp_valid)
               state_d = cmt_pkg::LSU_IDLE;       // Head fires this cycle
         default:
            state_d = cmt_pkg::LSU_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state_q <= cmt_pkg::LSU_IDLE;
      else
         state_q <= state_d;
   end

   // Capture the head access once, fields stay put until the next one
   always_ff @(posedge clk)
   begin
      if (state_q == cmt_pkg::LSU_IDLE && head_lsu_req)
      begin
         opc_q   <= cmt_lsu_opc0;
         addr_q  <= cmt_opera0;
         wdata_q <= cmt_operb0;
      end
   end

   assign is_store  = opc_q inside {cmt_pkg::LSU_SB, cmt_pkg::LSU_SH, cmt_pkg::LSU_SW};
   assign is_byte   = opc_q inside {cmt_pkg::LSU_LB, cmt_pkg::LSU_LBU, cmt_pkg::LSU_SB};
   assign is_half   = opc_q inside {cmt_pkg::LSU_LH, cmt_pkg::LSU_LHU, cmt_pkg::LSU_SH};
   assign is_signed = opc_q inside {cmt_pkg::LSU_LB, cmt_pkg::LSU_LH};

   // Request side
   assign dbus_req_valid = (state_q == cmt_pkg::LSU_REQ);
   assign dbus_req_write = is_store;
   assign dbus_req_addr  = {addr_q[cmt_pkg::AW-1:2], 2'b00};   // Word aligned

   always_comb
   begin
      if (is_byte)
      begin
         dbus_req_strb  = {{(cmt_pkg::STRB_W-1){1'b0}}, 1'b1} << addr_q[1:0];
         dbus_req_wdata = {cmt_pkg::STRB_W{wdata_q[7:0]}};       // Same byte in every lane
      end
      else if (is_half)
      begin
         dbus_req_strb  = addr_q[1] ? {{(cmt_pkg::STRB_W/2){1'b1}}, {(cmt_pkg::STRB_W/2){1'b0}}}
                                    : {{(cmt_pkg::STRB_W/2){1'b0}}, {(cmt_pkg::STRB_W/2){1'b1}}};
         dbus_req_wdata = {(cmt_pkg::STRB_W/2){wdata_q[15:0]}};
      end
      else
      begin
         dbus_req_strb  = {cmt_pkg::STRB_W{1'b1}};
         dbus_req_wdata = wdata_q;
      end
   end

   // Response side
   assign lsu_finish = (state_q == cmt_pkg::LSU_RESP) & dbus_rsp_valid;
   assign prf_we     = lsu_finish & ~is_store & cmt_prd_we0;

   assign ld_byte = dbus_rsp_rdata[{addr_q[1:0], 3'b000} +: 8];
   assign ld_half = dbus_rsp_rdata[{addr_q[1], 4'b0000} +: 16];

   always_comb
   begin
      if (is_byte)
         prf_wdata = {{(cmt_pkg::DW-8){is_signed & ld_byte[7]}}, ld_byte};
      else if (is_half)
         prf_wdata = {{(cmt_pkg::DW-16){is_signed & ld_half[15]}}, ld_half};
      else
         prf_wdata = dbus_rsp_rdata;
   end

endmodule

/* logic/cmt_branch_resolve.sv */
/*
 Self-flush and branch predictor update for the head entry.
 flush is a one-cycle pulse the cycle after a committed fls entry.
 The predictor update is combinational and valid only with bpu_wb.
 */

module cmt_branch_resolve
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          head_br_commit,
   input  logic                          head_fls_commit,
   input  logic [cmt_pkg::PC_W-1:0]      cmt_fls_tgt,
   input  logic [cmt_pkg::PC_W-1:0]      cmt_pc0,
   input  cmt_pkg::br_kind_e             cmt_br_kind0,
   input  logic                          cmt_bpu_taken,
   input  logic [cmt_pkg::PC_W-1:0]      cmt_bpu_tgt,
   output logic                          flush,
   output logic [cmt_pkg::PC_W-1:0]      flush_tgt,
   output logic                          bpu_wb,
   output cmt_pkg::br_kind_e             bpu_wb_kind,
   output logic                          bpu_wb_taken,
   output logic [cmt_pkg::PC_W-1:0]      bpu_wb_pc,
   output logic [cmt_pkg::PC_W-1:0]      bpu_wb_npc_act
);

   // No fire happens while flush is high, so this falls after one cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         flush <= 1'b0;
      else
         flush <= head_fls_commit;
   end

   always_ff @(posedge clk)
   begin
      if (head_fls_commit)
         flush_tgt <= cmt_fls_tgt;                // Redirect PC for the front end
   end

   // A flushing branch was mispredicted, so flip the direction and take
   // the resolved target instead of the predicted one
   assign bpu_wb         = head_br_commit;
   assign bpu_wb_kind    = cmt_br_kind0;
   assign bpu_wb_pc      = cmt_pc0;
   assign bpu_wb_taken   = cmt_bpu_taken ^ head_fls_commit;
   assign bpu_wb_npc_act = head_fls_commit ? cmt_fls_tgt : cmt_bpu_tgt;

endmodule

/* logic/cmt_select.sv */
/*
 Commit window arbitration, fully combinational.
 Loads, stores, branches and self-flushing entries retire only alone at
 the head. A head load or store holds the whole window until lsu_finish.
 */

module cmt_select
(
   input  logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_valid,
   input  cmt_pkg::lsu_opc_e [cmt_pkg::COMMIT_WIDTH-1:0] cmt_lsu_opc,
   input  cmt_pkg::br_kind_e [cmt_pkg::COMMIT_WIDTH-1:0] cmt_br_kind,
   input  logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_fls,
   input  logic                                          flush,
   input  logic                                          lsu_finish,
   output logic [cmt_pkg::COMMIT_WIDTH-1:0]              cmt_fire,
   output logic [cmt_pkg::POP_W-1:0]                     cmt_pop_size,
   output logic                                          head_lsu_req,
   output logic                                          head_br_commit,
   output logic                                          head_fls_commit
);

   logic [cmt_pkg::COMMIT_WIDTH-1:0] is_lsu;
   logic [cmt_pkg::COMMIT_WIDTH-1:0] is_br;
   logic [cmt_pkg::COMMIT_WIDTH-1:0] serial;
   logic [cmt_pkg::COMMIT_WIDTH-1:0] mask;
   logic [cmt_pkg::COMMIT_WIDTH-1:0] ready;
   logic                             head_lsu;
   logic                             cmt_ce;

   // Per-channel classification
   always_comb
   begin
      for (int i = 0; i < cmt_pkg::COMMIT_WIDTH; i++)
      begin
         is_lsu[i] = (cmt_lsu_opc[i] != cmt_pkg::LSU_NONE);
         is_br[i]  = (cmt_br_kind[i] != cmt_pkg::BR_NONE);
         serial[i] = is_lsu[i] | is_br[i] | cmt_fls[i];
      end
   end

   // Prefix mask: a serializing entry stops the window at itself,
   // and only channel 0 may be serializing
   always_comb
   begin
      mask[0] = 1'b1;
      mask[1] = ~serial[0] & ~serial[1];
      for (int j = 2; j < cmt_pkg::COMMIT_WIDTH; j++)
         mask[j] = mask[j-1] & ~serial[j];
   end

   assign ready    = cmt_valid & mask;
   assign head_lsu = cmt_valid[0] & is_lsu[0];
   assign cmt_ce   = ~head_lsu | lsu_finish;         // Stall on pending access

   assign cmt_fire = ready & {cmt_pkg::COMMIT_WIDTH{cmt_ce & ~flush}};

   always_comb
   begin
      cmt_pop_size = '0;
      for (int i = 0; i < cmt_pkg::COMMIT_WIDTH; i++)
         cmt_pop_size = cmt_pop_size + {{(cmt_pkg::POP_W-1){1'b0}}, cmt_fire[i]};
   end

   assign head_lsu_req    = head_lsu & ~flush;        // Mask is always set at 0
   assign head_br_commit  = cmt_fire[0] & is_br[0];
   assign head_fls_commit = cmt_fire[0] & cmt_fls[0];

endmodule

/* logic/cmt_pkg.sv */
/*
 Shared widths and encodings for the commit stage.
 The commit window is fixed at four entries and the PC is a word PC.
 The enum encodings are visible on the top-level ports, so any change
 here also changes the ROB and predictor side.
 */

package cmt_pkg;

   localparam int COMMIT_WIDTH = 4;          // ROB entries examined per cycle
   localparam int POP_W        = 3;          // Holds 0..COMMIT_WIDTH
   localparam int DW           = 32;
   localparam int PC_W         = 30;         // Word PC, byte bits dropped
   localparam int AW           = 32;         // Byte address on the data bus
   localparam int STRB_W       = DW / 8;
   localparam int PRF_AW       = 6;

   // LSU opcodes carried by each ROB entry
   typedef enum logic [3:0] {
      LSU_NONE = 4'd0,
      LSU_LB   = 4'd1,
      LSU_LBU  = 4'd2,
      LSU_LH   = 4'd3,
      LSU_LHU  = 4'd4,
      LSU_LW   = 4'd5,
      LSU_SB   = 4'd6,
      LSU_SH   = 4'd7,
      LSU_SW   = 4'd8
   } lsu_opc_e;

   typedef enum logic [1:0] {
      BR_NONE = 2'd0,
      BR_BCC  = 2'd1,                        // Conditional
      BR_BREL = 2'd2,                        // PC-relative jump
      BR_BREG = 2'd3                         // Register jump
   } br_kind_e;

   typedef enum logic [1:0] {
      LSU_IDLE = 2'd0,
      LSU_REQ  = 2'd1,
      LSU_RESP = 2'd2
   } lsu_state_e;

endpackage
